// File: scope_pkg.sv
// Shared sizes, stream beat types and channel states for the triggered capture block
`default_nettype none

package scope_pkg;

    // Channel count and channel number width
    localparam int N_CHANNELS = 4;
    localparam int CHANNEL_BITS = 2;

    // Ring buffer geometry
    localparam int BUFFER_DEPTH = 64;
    localparam int ADDRESS_BITS = 6;

    // Register stages after the memory read register
    localparam int READ_PIPE = 1;
    // Address to data at the channel port
    localparam int READ_LATENCY = READ_PIPE + 1;

    // Sample payload widths
    localparam int SAMPLE_BITS = 16;
    localparam int USER_BITS = 8;

    // Word kept in each buffer entry
    typedef struct packed {
        logic [SAMPLE_BITS-1:0] data;
        // Side-band tag, stored untouched
        logic [USER_BITS-1:0] user;
    } sample_t;

    // Input stream beat, a plain strobe
    typedef struct packed {
        logic valid;
        logic [CHANNEL_BITS-1:0] dest;
        sample_t sample;
    } in_beat_t;

    // Output stream beat, last marks the end of one channel
    typedef struct packed {
        logic valid;
        logic last;
        logic [CHANNEL_BITS-1:0] dest;
        sample_t sample;
    } out_beat_t;

    // Capture channel states
    typedef enum logic [1:0] {
        idle = 2'd0,
        pre_trigger = 2'd1,
        acquisition = 2'd2,
        stopped = 2'd3
    } channel_state_t;

endpackage

`default_nettype wire

// File: channel_router.sv
// Feeder that sorts input beats by dest and hands each channel its pending trigger
`timescale 1ns/1ps
`default_nettype none

module channel_router (
    input wire logic clock,
    input wire logic rst,
    input wire logic arm,
    input wire logic trigger,
    input scope_pkg::in_beat_t in_beat,
    output logic [scope_pkg::N_CHANNELS-1:0] write_strobe,
    output scope_pkg::sample_t write_sample,
    output logic [scope_pkg::N_CHANNELS-1:0] write_trigger,
    output logic channel_arm
);

    // One outstanding trigger per channel
    logic [scope_pkg::N_CHANNELS-1:0] pending;
    // Beat decoded to its channel before the register
    logic [scope_pkg::N_CHANNELS-1:0] beat_hit;
    // Trigger seen by each channel this cycle
    logic [scope_pkg::N_CHANNELS-1:0] trigger_now;

    // One-hot decode of dest
    // A dest with no matching channel gives no strobe
    always_comb begin
        for (int i = 0; i < scope_pkg::N_CHANNELS; i++) begin
            beat_hit[i] = in_beat.valid && (in_beat.dest == scope_pkg::CHANNEL_BITS'(i));
        end
    end

    // A trigger in the same cycle as a beat applies to that beat
    assign trigger_now = pending | {scope_pkg::N_CHANNELS{trigger}};

    // Sample payload follows the beat by one cycle
    always_ff @(posedge clock) begin
        write_sample <= in_beat.sample;
    end

    // Strobes and trigger flags one cycle behind the input
    always_ff @(posedge clock) begin
        if (rst) begin
            write_strobe <= '0;
            write_trigger <= '0;
            channel_arm <= 1'b0;
        end else begin
            channel_arm <= arm;
            // Beats arriving with arm belong to no capture
            write_strobe <= arm ? '0 : beat_hit;
            write_trigger <= arm ? '0 : (beat_hit & trigger_now);
        end
    end

    // Pending trigger flags
    always_ff @(posedge clock) begin
        if (rst) begin
            pending <= '0;
        end else if (arm) begin
            // New capture drops any old trigger
            pending <= '0;
        end else begin
            for (int i = 0; i < scope_pkg::N_CHANNELS; i++) begin
                if (beat_hit[i]) begin
                    // Consumed by this beat
                    pending[i] <= 1'b0;
                end else if (trigger) begin
                    pending[i] <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: capture_channel.sv
// Ring-buffer capture channel with pre-trigger history and a pipelined read port
`timescale 1ns/1ps
`default_nettype none

module capture_channel (
    input wire logic clock,
    input wire logic rst,
    input wire logic arm,
    input wire logic [scope_pkg::ADDRESS_BITS-1:0] trigger_point,
    input wire logic write_strobe,
    input wire logic write_trigger,
    input scope_pkg::sample_t write_sample,
    input wire logic read_enable,
    input wire logic [scope_pkg::ADDRESS_BITS-1:0] read_address,
    input wire logic release_channel,
    output scope_pkg::sample_t read_sample,
    output logic [scope_pkg::ADDRESS_BITS-1:0] start_address,
    output logic stopped
);

    // Sample storage
    scope_pkg::sample_t memory [scope_pkg::BUFFER_DEPTH];

    scope_pkg::channel_state_t state;
    logic [scope_pkg::ADDRESS_BITS-1:0] write_address;
    // Samples still to store after the trigger sample
    logic [scope_pkg::ADDRESS_BITS-1:0] remaining;
    logic memory_write;
    logic trigger_taken;

    // Read path registers
    scope_pkg::sample_t read_register;
    scope_pkg::sample_t read_pipe [scope_pkg::READ_PIPE];

    // Writes only while capturing and never in the arm cycle
    assign memory_write = write_strobe && !arm &&
        ((state == scope_pkg::pre_trigger) || (state == scope_pkg::acquisition));

    // Trigger sample marks the window
    assign trigger_taken = write_strobe && write_trigger && !arm &&
        (state == scope_pkg::pre_trigger);

    assign stopped = (state == scope_pkg::stopped);

    always_ff @(posedge clock) begin
        if (memory_write) begin
            memory[write_address] <= write_sample;
        end
    end

    // Capture state machine
    always_ff @(posedge clock) begin
        if (rst) begin
            state <= scope_pkg::idle;
            write_address <= '0;
            remaining <= '0;
            start_address <= '0;
        end else if (arm) begin
            state <= scope_pkg::pre_trigger;
            write_address <= '0;
        end else begin
            if (memory_write) begin
                // Wraps modulo the depth
                write_address <= write_address + 1'b1;
            end
            case (state)
                scope_pkg::pre_trigger: begin
                    if (trigger_taken) begin
                        // Oldest kept sample sits trigger_point entries back
                        start_address <= write_address - trigger_point;
                        remaining <= scope_pkg::ADDRESS_BITS'(scope_pkg::BUFFER_DEPTH - 1)
                            - trigger_point;
                        // Trigger sample fills the last slot
                        if (trigger_point == scope_pkg::ADDRESS_BITS'(scope_pkg::BUFFER_DEPTH - 1))
                        begin
                            state <= scope_pkg::stopped;
                        end else begin
                            state <= scope_pkg::acquisition;
                        end
                    end
                end
                scope_pkg::acquisition: begin
                    if (write_strobe) begin
                        remaining <= remaining - 1'b1;
                        if (remaining == scope_pkg::ADDRESS_BITS'(1)) begin
                            state <= scope_pkg::stopped;
                        end
                    end
                end
                scope_pkg::stopped: begin
                    // Buffer fully drained
                    if (release_channel) begin
                        state <= scope_pkg::idle;
                    end
                end
                default: begin
                    state <= scope_pkg::idle;
                end
            endcase
        end
    end

    // Memory read register followed by the pipeline
    always_ff @(posedge clock) begin
        if (read_enable) begin
            read_register <= memory[read_address];
        end
        read_pipe[0] <= read_register;
        for (int i = 1; i < scope_pkg::READ_PIPE; i++) begin
            read_pipe[i] <= read_pipe[i-1];
        end
    end

    assign read_sample = read_pipe[scope_pkg::READ_PIPE-1];

    // A full window ends back at its start address and holds there while stopped
    assert property (@(posedge clock) disable iff (rst)
        stopped |-> (write_address == start_address))
    else $error("write address left the window start while channel stopped");

    // Trigger flags reach a channel only while it waits for one
    assert property (@(posedge clock) disable iff (rst)
        (write_strobe && write_trigger && !arm) |-> (state == scope_pkg::pre_trigger))
    else $error("trigger taken outside pre_trigger");

    // Readout only releases a finished channel
    assert property (@(posedge clock) disable iff (rst)
        release_channel |-> stopped)
    else $error("release seen while channel not stopped");

endmodule

`default_nettype wire

// File: readout_sequencer.sv
// Drain that reads every stopped channel in time order onto one tagged output stream
`timescale 1ns/1ps
`default_nettype none

module readout_sequencer (
    input wire logic clock,
    input wire logic rst,
    input wire logic arm,
    input wire logic [scope_pkg::N_CHANNELS-1:0] stopped,
    input wire logic [scope_pkg::ADDRESS_BITS-1:0] start_address [scope_pkg::N_CHANNELS],
    input scope_pkg::sample_t read_sample [scope_pkg::N_CHANNELS],
    output logic [scope_pkg::N_CHANNELS-1:0] read_enable,
    output logic [scope_pkg::ADDRESS_BITS-1:0] read_address,
    output logic release_channel,
    output scope_pkg::out_beat_t out_beat,
    output logic done,
    output logic busy
);

    // Beat tag travelling alongside the memory read
    typedef struct packed {
        logic valid;
        logic last;
        logic [scope_pkg::CHANNEL_BITS-1:0] dest;
    } read_tag_t;

    logic reading;
    logic draining;
    // Idle cycle between channels
    logic gap;
    logic issue;
    logic [scope_pkg::CHANNEL_BITS-1:0] channel;
    logic [scope_pkg::ADDRESS_BITS-1:0] offset;
    read_tag_t issue_tag;
    read_tag_t tag_pipe [scope_pkg::READ_LATENCY];

    assign issue = reading && !gap;

    // Oldest sample first, wraps modulo the depth
    assign read_address = start_address[channel] + offset;

    always_comb begin
        read_enable = '0;
        read_enable[channel] = issue;
    end

    assign issue_tag.valid = issue;
    assign issue_tag.last = (offset == '1);
    assign issue_tag.dest = channel;

    // Channel and offset walk
    always_ff @(posedge clock) begin
        if (rst) begin
            busy <= 1'b0;
            reading <= 1'b0;
            draining <= 1'b0;
            gap <= 1'b0;
            channel <= '0;
            offset <= '0;
        end else begin
            if (done) begin
                busy <= 1'b0;
                draining <= 1'b0;
            end else if (arm) begin
                busy <= 1'b1;
            end
            if (busy && !reading && !draining && (&stopped)) begin
                reading <= 1'b1;
                channel <= '0;
                offset <= '0;
                gap <= 1'b0;
            end else if (gap) begin
                gap <= 1'b0;
            end else if (reading) begin
                offset <= offset + 1'b1;
                if (offset == '1) begin
                    if (channel == scope_pkg::CHANNEL_BITS'(scope_pkg::N_CHANNELS - 1)) begin
                        // Last address issued, wait for the data
                        reading <= 1'b0;
                        draining <= 1'b1;
                    end else begin
                        channel <= channel + 1'b1;
                        gap <= 1'b1;
                    end
                end
            end
        end
    end

    // Tag delay matched to the channel read latency
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < scope_pkg::READ_LATENCY; i++) begin
                tag_pipe[i] <= '0;
            end
        end else begin
            tag_pipe[0] <= issue_tag;
            for (int i = 1; i < scope_pkg::READ_LATENCY; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    // Output register, sample picked by the tagged channel
    always_ff @(posedge clock) begin
        out_beat.sample <= read_sample[tag_pipe[scope_pkg::READ_LATENCY-1].dest];
        out_beat.dest <= tag_pipe[scope_pkg::READ_LATENCY-1].dest;
        if (rst) begin
            out_beat.valid <= 1'b0;
            out_beat.last <= 1'b0;
            done <= 1'b0;
            release_channel <= 1'b0;
        end else begin
            out_beat.valid <= tag_pipe[scope_pkg::READ_LATENCY-1].valid;
            out_beat.last <= tag_pipe[scope_pkg::READ_LATENCY-1].last;
            // End one cycle after the final beat
            done <= out_beat.valid && out_beat.last &&
                (out_beat.dest == scope_pkg::CHANNEL_BITS'(scope_pkg::N_CHANNELS - 1));
            release_channel <= out_beat.valid && out_beat.last &&
                (out_beat.dest == scope_pkg::CHANNEL_BITS'(scope_pkg::N_CHANNELS - 1));
        end
    end

    // Reads only once every channel has stopped
    assert property (@(posedge clock) disable iff (rst)
        (|read_enable) |-> (&stopped))
    else $error("read issued while a channel is still capturing");

endmodule

`default_nettype wire

// File: capture_top.sv
// Four-channel triggered capture top with router, ring-buffer channels and readout
`timescale 1ns/1ps
`default_nettype none

module capture_top (
    input wire logic clock,
    input wire logic rst,
    input wire logic arm,
    input wire logic trigger,
    input wire logic [scope_pkg::ADDRESS_BITS-1:0] trigger_point,
    input scope_pkg::in_beat_t in_beat,
    output scope_pkg::out_beat_t out_beat,
    output logic done,
    output logic busy
);

    // Router to channels
    logic [scope_pkg::N_CHANNELS-1:0] write_strobe;
    logic [scope_pkg::N_CHANNELS-1:0] write_trigger;
    scope_pkg::sample_t write_sample;
    logic channel_arm;

    // Channels to sequencer
    logic [scope_pkg::N_CHANNELS-1:0] stopped;
    logic [scope_pkg::ADDRESS_BITS-1:0] start_address [scope_pkg::N_CHANNELS];
    scope_pkg::sample_t read_sample [scope_pkg::N_CHANNELS];

    // Sequencer to channels, address shared by all
    logic [scope_pkg::N_CHANNELS-1:0] read_enable;
    logic [scope_pkg::ADDRESS_BITS-1:0] read_address;
    logic release_channel;

    channel_router router (
        .clock(clock),
        .rst(rst),
        .arm(arm),
        .trigger(trigger),
        .in_beat(in_beat),
        .write_strobe(write_strobe),
        .write_sample(write_sample),
        .write_trigger(write_trigger),
        .channel_arm(channel_arm)
    );

    // One ring buffer per channel
    for (genvar i = 0; i < scope_pkg::N_CHANNELS; i++) begin : g_channel
        capture_channel channel (
            .clock(clock),
            .rst(rst),
            .arm(channel_arm),
            .trigger_point(trigger_point),
            .write_strobe(write_strobe[i]),
            .write_trigger(write_trigger[i]),
            .write_sample(write_sample),
            .read_enable(read_enable[i]),
            .read_address(read_address),
            .release_channel(release_channel),
            .read_sample(read_sample[i]),
            .start_address(start_address[i]),
            .stopped(stopped[i])
        );
    end

    readout_sequencer sequencer (
        .clock(clock),
        .rst(rst),
        .arm(arm),
        .stopped(stopped),
        .start_address(start_address),
        .read_sample(read_sample),
        .read_enable(read_enable),
        .read_address(read_address),
        .release_channel(release_channel),
        .out_beat(out_beat),
        .done(done),
        .busy(busy)
    );

endmodule

`default_nettype wire

// File: tb_capture_top.sv
// Directed testbench for the four-channel triggered capture block with a ring-buffer model
`timescale 1ns/1ps
`default_nettype none

module tb_capture_top;

    // Eight captures of 256 output beats each
    localparam int TOTAL_BEATS = 8 * 256;
    localparam int CYCLE_LIMIT = 4 * TOTAL_BEATS + 2000;
    localparam int DONE_WAIT = 1000;
    // Ways of picking dest
    localparam int ROUND_ROBIN = 0;
    localparam int RANDOM_DEST = 1;
    localparam int FIXED_DEST = 2;
    localparam int N = scope_pkg::N_CHANNELS;
    localparam int DEPTH = scope_pkg::BUFFER_DEPTH;

    logic clock;
    logic rst;
    logic arm;
    logic trigger;
    logic [scope_pkg::ADDRESS_BITS-1:0] trigger_point;
    scope_pkg::in_beat_t in_beat;
    scope_pkg::out_beat_t out_beat;
    logic done;
    logic busy;

    integer seed;
    int cycles;
    int capture_tp;
    int test_errors;
    int total_errors;
    int tests_passed;
    int tests_failed;
    int done_count;
    scope_pkg::out_beat_t beats [$];

    // Image of each channel buffer and which entries hold known data
    scope_pkg::sample_t model_mem [N][DEPTH];
    bit model_known [N][DEPTH];
    scope_pkg::channel_state_t model_state [N];
    int model_addr [N];
    int model_left [N];
    int model_start [N];
    int model_count [N];
    bit model_pending [N];

    capture_top UUT (
        .clock(clock),
        .rst(rst),
        .arm(arm),
        .trigger(trigger),
        .trigger_point(trigger_point),
        .in_beat(in_beat),
        .out_beat(out_beat),
        .done(done),
        .busy(busy)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Hard stop for a hung run
    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d clock cycles without finishing", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // Output collector sampled mid-cycle
    always @(negedge clock) begin
        if (out_beat.valid === 1'b1) begin
            beats.push_back(out_beat);
        end
        if (done === 1'b1) begin
            done_count = done_count + 1;
        end
    end

    function automatic bit all_stopped();
        bit result;
        result = 1'b1;
        for (int c = 0; c < N; c++) begin
            if (model_state[c] != scope_pkg::stopped) begin
                result = 1'b0;
            end
        end
        return result;
    endfunction

    function automatic int min_count();
        int low;
        low = model_count[0];
        for (int c = 1; c < N; c++) begin
            if (model_count[c] < low) begin
                low = model_count[c];
            end
        end
        return low;
    endfunction

    // Ring buffer rules for one accepted beat
    task automatic store_sample(input int c, input scope_pkg::sample_t sample, input bit take);
        if (model_state[c] == scope_pkg::pre_trigger || model_state[c] == scope_pkg::acquisition)
        begin
            model_mem[c][model_addr[c]] = sample;
            model_known[c][model_addr[c]] = 1'b1;
            if (model_state[c] == scope_pkg::pre_trigger && take) begin
                // Window opens trigger_point entries back
                model_start[c] = (model_addr[c] - capture_tp + DEPTH) % DEPTH;
                model_left[c] = DEPTH - 1 - capture_tp;
                model_state[c] = (model_left[c] == 0) ? scope_pkg::stopped
                    : scope_pkg::acquisition;
            end else if (model_state[c] == scope_pkg::acquisition) begin
                model_left[c] = model_left[c] - 1;
                if (model_left[c] == 0) begin
                    model_state[c] = scope_pkg::stopped;
                end
            end
            model_addr[c] = (model_addr[c] + 1) % DEPTH;
            model_count[c] = model_count[c] + 1;
        end
    endtask

    // One input cycle driven on the falling edge with the model updated alongside
    task automatic drive_cycle(input bit valid, input int dest, input bit trig, input bit arm_now);
        scope_pkg::sample_t sample;
        bit take;
        sample.data = 16'($random(seed));
        sample.user = 8'($random(seed));
        @(negedge clock);
        arm = arm_now;
        trigger = trig;
        trigger_point = scope_pkg::ADDRESS_BITS'(capture_tp);
        in_beat.valid = valid;
        in_beat.dest = scope_pkg::CHANNEL_BITS'(dest);
        in_beat.sample = sample;
        for (int c = 0; c < N; c++) begin
            if (arm_now) begin
                model_state[c] = scope_pkg::pre_trigger;
                model_addr[c] = 0;
                model_count[c] = 0;
                model_pending[c] = 1'b0;
            end else if (valid && dest == c) begin
                // Same-cycle trigger belongs to this beat
                take = model_pending[c] || trig;
                model_pending[c] = 1'b0;
                store_sample(c, sample, take);
            end else if (trig) begin
                model_pending[c] = 1'b1;
            end
        end
    endtask

    task automatic send_beats(input int count, input int mode, input int fixed_dest);
        int dest;
        for (int i = 0; i < count; i++) begin
            if (mode == ROUND_ROBIN) begin
                dest = i % N;
            end else if (mode == RANDOM_DEST) begin
                dest = $unsigned($random(seed)) % N;
            end else begin
                dest = fixed_dest;
            end
            drive_cycle(1'b1, dest, 1'b0, 1'b0);
        end
    endtask

    // Keep feeding until every channel window is full
    task automatic send_until_stopped(input int mode);
        int guard;
        guard = 0;
        while (!all_stopped() && guard < 2000) begin
            if (mode == ROUND_ROBIN) begin
                // One beat for each channel per round
                send_beats(N, ROUND_ROBIN, 0);
            end else begin
                send_beats(1, mode, 0);
            end
            guard = guard + 1;
        end
    endtask

    task automatic arm_capture(input int tp);
        beats.delete();
        done_count = 0;
        test_errors = 0;
        capture_tp = tp;
        drive_cycle(1'b0, 0, 1'b0, 1'b1);
        drive_cycle(1'b0, 0, 1'b0, 1'b0);
        if (busy !== 1'b1) begin
            $display("MISMATCH at %0t: busy is %b after arm, expected 1", $time, busy);
            test_errors++;
        end
    endtask

    // Wait for done and compare all 256 beats with the model
    task automatic finish_capture(input string name);
        int waited;
        int index;
        int addr;
        scope_pkg::out_beat_t got;
        drive_cycle(1'b0, 0, 1'b0, 1'b0);
        waited = 0;
        while (done !== 1'b1 && waited < DONE_WAIT) begin
            @(negedge clock);
            waited++;
        end
        if (done !== 1'b1) begin
            $display("Test %s: done did not pulse within %0d cycles", name, DONE_WAIT);
            test_errors++;
        end
        @(negedge clock);
        if (busy !== 1'b0) begin
            $display("MISMATCH at %0t: busy is %b after done, expected 0", $time, busy);
            test_errors++;
        end
        repeat (4) @(negedge clock);
        if (done_count != 1) begin
            $display("MISMATCH at %0t: done pulsed %0d times, expected 1", $time, done_count);
            test_errors++;
        end
        if (beats.size() != N * DEPTH) begin
            $display("MISMATCH at %0t: %0d output beats, expected %0d", $time, beats.size(),
                N * DEPTH);
            test_errors++;
        end
        for (index = 0; index < beats.size() && index < N * DEPTH; index++) begin
            got = beats[index];
            addr = (model_start[index / DEPTH] + index % DEPTH) % DEPTH;
            if (got.dest != scope_pkg::CHANNEL_BITS'(index / DEPTH) ||
                got.last != (index % DEPTH == DEPTH - 1)) begin
                $display("MISMATCH at %0t: beat %0d dest %0d last %b", $time, index,
                    got.dest, got.last);
                test_errors++;
            end
            // Entries never written since reset have no defined value
            if (model_known[index / DEPTH][addr] &&
                got.sample != model_mem[index / DEPTH][addr]) begin
                $display("MISMATCH at %0t: beat %0d sample %h, expected %h", $time, index,
                    got.sample, model_mem[index / DEPTH][addr]);
                test_errors++;
            end
        end
        $display("%s: %s with %0d errors", name, (test_errors == 0) ? "ok" : "FAILED",
            test_errors);
        if (test_errors == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        total_errors += test_errors;
    endtask

    initial begin
        seed = 38;
        rst = 1'b1;
        arm = 1'b0;
        trigger = 1'b0;
        trigger_point = '0;
        in_beat = '0;
        capture_tp = 0;
        for (int c = 0; c < N; c++) begin
            model_state[c] = scope_pkg::idle;
        end
        repeat (10) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        // Only channel 0 has history before the trigger on its 21st sample
        arm_capture(16);
        send_beats(20, FIXED_DEST, 0);
        drive_cycle(1'b1, 0, 1'b1, 1'b0);
        send_until_stopped(ROUND_ROBIN);
        finish_capture("single channel trigger_point 16");

        // Random dest throughout with one trigger
        arm_capture(20);
        while (min_count() < 20) begin
            send_beats(1, RANDOM_DEST, 0);
        end
        drive_cycle(1'b1, $unsigned($random(seed)) % N, 1'b1, 1'b0);
        send_until_stopped(RANDOM_DEST);
        finish_capture("interleaved channels");

        // 80 samples per channel before the trigger
        arm_capture(10);
        send_beats(4 * 80, ROUND_ROBIN, 0);
        drive_cycle(1'b1, 0, 1'b1, 1'b0);
        send_until_stopped(ROUND_ROBIN);
        finish_capture("wrap-around");

        arm_capture(0);
        drive_cycle(1'b1, 1, 1'b1, 1'b0);
        send_until_stopped(ROUND_ROBIN);
        finish_capture("trigger_point 0");
        arm_capture(63);
        send_beats(4 * 63, ROUND_ROBIN, 0);
        drive_cycle(1'b1, 2, 1'b1, 1'b0);
        send_until_stopped(ROUND_ROBIN);
        finish_capture("trigger_point 63");

        // Channel 3 history and idle beats before the trigger and late beats after the stop
        arm_capture(8);
        send_beats(12, FIXED_DEST, 3);
        repeat (6) drive_cycle(1'b0, $unsigned($random(seed)) % N, 1'b0, 1'b0);
        send_beats(4 * 8, ROUND_ROBIN, 0);
        drive_cycle(1'b1, 3, 1'b1, 1'b0);
        send_until_stopped(ROUND_ROBIN);
        send_beats(40, ROUND_ROBIN, 0);
        drive_cycle(1'b0, 2, 1'b0, 1'b0);
        finish_capture("stopped and invalid input");

        // Trigger on an idle cycle and an immediate second capture after it
        arm_capture(32);
        while (min_count() < 32) begin
            send_beats(1, RANDOM_DEST, 0);
        end
        drive_cycle(1'b0, 0, 1'b1, 1'b0);
        send_until_stopped(RANDOM_DEST);
        finish_capture("re-arm first capture");
        arm_capture(5);
        send_beats(24, ROUND_ROBIN, 0);
        drive_cycle(1'b1, 1, 1'b1, 1'b0);
        send_until_stopped(RANDOM_DEST);
        finish_capture("re-arm second capture");

        $display("Summary: %0d tests passed, %0d tests failed, %0d errors", tests_passed,
            tests_failed, total_errors);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
scope_pkg.sv
channel_router.sv
capture_channel.sv
readout_sequencer.sv
capture_top.sv
tb_capture_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

# Warnings stay visible but do not stop the build
verilator --binary --assert -Wno-fatal \
    --top-module tb_capture_top \
    -f project.f \
    -o sim_capture
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/sim_capture > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "Simulation run exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$log_file"; then
    echo "Testbench reported failure"
    exit 1
fi

if ! grep -q "Simulation passed" "$log_file"; then
    echo "Testbench ended without a result"
    exit 1
fi

exit 0
